/* design/capture_cfg.svh */
`ifndef CAPTURE_CFG_SVH
`define CAPTURE_CFG_SVH

// samples packed into one RAM word
`define CAP_WORD_W 16

// RAM depth is 2**CAP_ADDR_W words
`define CAP_ADDR_W 8

// clocks per serial bit, board builds use clk_hz / baud
`define UART_CLKS_PER_BIT 16

`endif

/* design/capture_pkg.sv */
`default_nettype none

`include "capture_cfg.svh"

package capture_pkg;

    // sequencer states
    typedef enum logic [2:0] {
        idle,       // one cycle after reset
        capture,    // sampler running, words go to RAM
        fetch,      // RAM read in flight
        send_lo,    // low byte to UART
        send_hi,    // high byte to UART
        done        // dump finished, waits for start
    } seq_state_e;

    // one RAM write, sequencer to RAM
    typedef struct packed {
        logic                   en;
        logic [`CAP_ADDR_W-1:0] addr;
        logic [`CAP_WORD_W-1:0] data;
    } ram_wr_t;

    // request half of the byte handshake
    typedef struct packed {
        logic       req;
        logic [7:0] data;
    } byte_req_t;

endpackage

`default_nettype wire

/* design/bit_sampler.sv */
`timescale 1ns/100ps
`default_nettype none

`include "capture_cfg.svh"

module bit_sampler (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enable,
    input  logic                   sig,
    output logic [`CAP_WORD_W-1:0] word,
    output logic                   word_stb
);

    localparam int CNT_W = $clog2(`CAP_WORD_W);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`CAP_WORD_W - 1);

    logic [`CAP_WORD_W-1:0] shreg;  // newest sample at bit 0
    logic [CNT_W-1:0]       cnt;    // samples taken in this word

    // payload, no reset needed
    always_ff @(posedge clk) begin
        if (enable) begin
            shreg <= {shreg[`CAP_WORD_W-2:0], sig};
        end
    end

    // counter sits at zero while disabled, so a rising enable starts a fresh word
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= '0;
            word_stb <= 1'b0;
        end else if (!enable) begin
            cnt      <= '0;
            word_stb <= 1'b0;
        end else begin
            word_stb <= (cnt == LAST);          // full word after this sample
            if (cnt == LAST) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign word = shreg;                    // first sample lands in the msb

    // one strobe per word, words are many clocks apart
    a_stb_single : assert property (
        @(posedge clk) disable iff (rst)
        word_stb |=> !word_stb
    );

endmodule

`default_nettype wire

/* design/capture_ram.sv */
`timescale 1ns/100ps
`default_nettype none

`include "capture_cfg.svh"

module capture_ram (
    input  logic                   clk,
    input  capture_pkg::ram_wr_t   wr,
    input  logic [`CAP_ADDR_W-1:0] rd_addr,
    output logic [`CAP_WORD_W-1:0] rd_data
);

    localparam int DEPTH = 2 ** `CAP_ADDR_W;

    logic [`CAP_WORD_W-1:0] mem [0:DEPTH-1];

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read, maps onto block RAM
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* design/dump_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "capture_cfg.svh"

module dump_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [`CAP_WORD_W-1:0] word,
    input  logic                   word_stb,
    output logic                   sample_en,
    output capture_pkg::ram_wr_t   wr,
    output logic [`CAP_ADDR_W-1:0] rd_addr,
    input  logic [`CAP_WORD_W-1:0] rd_data,
    output capture_pkg::byte_req_t tx_req,
    input  logic                   ack,
    output logic                   busy,
    output logic                   done
);

    capture_pkg::seq_state_e state;

    logic [`CAP_ADDR_W-1:0] addr;   // write pointer, then read pointer
    logic                   req_q;  // req phase of the handshake
    logic                   sent;   // ack seen, waiting for it to drop

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= capture_pkg::idle;
            addr  <= '0;
            req_q <= 1'b0;
            sent  <= 1'b0;
        end else begin
            case (state)
                capture_pkg::idle: begin
                    state <= capture_pkg::capture;  // capture right after reset
                    addr  <= '0;
                end

                capture_pkg::capture: begin
                    if (word_stb) begin
                        addr <= addr + 1'b1;
                        if (addr == '1) begin           // RAM full
                            state <= capture_pkg::fetch;
                        end
                    end
                end

                // rd_addr already valid, data shows up next cycle
                capture_pkg::fetch: begin
                    state <= capture_pkg::send_lo;
                end

                capture_pkg::send_lo,
                capture_pkg::send_hi: begin
                    if (!sent) begin
                        if (!req_q && !ack) begin
                            req_q <= 1'b1;
                        end else if (req_q && ack) begin
                            req_q <= 1'b0;
                            sent  <= 1'b1;
                        end
                    end else if (!ack) begin            // frame fully out
                        sent <= 1'b0;
                        if (state == capture_pkg::send_lo) begin
                            state <= capture_pkg::send_hi;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= (addr == '1) ? capture_pkg::done
                                                  : capture_pkg::fetch;
                        end
                    end
                end

                capture_pkg::done: begin
                    if (start) begin
                        state <= capture_pkg::capture;
                        addr  <= '0;
                    end
                end

                default: begin
                    state <= capture_pkg::idle;
                end
            endcase
        end
    end

    assign sample_en = (state == capture_pkg::capture);

    // the RAM never stalls, so the strobe goes straight through
    assign wr.en   = word_stb;
    assign wr.addr = addr;
    assign wr.data = word;

    assign rd_addr = addr;

    // rd_addr is frozen while sending, so rd_data holds steady
    assign tx_req.req  = req_q;
    assign tx_req.data = (state == capture_pkg::send_hi) ? rd_data[15:8] : rd_data[7:0];

    assign busy = (state == capture_pkg::capture) || (state == capture_pkg::fetch) ||
                  (state == capture_pkg::send_lo) || (state == capture_pkg::send_hi);
    assign done = (state == capture_pkg::done);

    // req is only withdrawn once the transmitter has taken the byte
    a_req_hold : assert property (
        @(posedge clk) disable iff (rst)
        $fell(tx_req.req) |-> $past(ack)
    );

    // byte stays put for the whole request
    a_data_stable : assert property (
        @(posedge clk) disable iff (rst)
        tx_req.req |=> (!tx_req.req || $stable(tx_req.data))
    );

endmodule

`default_nettype wire

/* design/uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

`include "capture_cfg.svh"

module uart_tx (
    input  logic                   clk,
    input  logic                   rst,
    input  capture_pkg::byte_req_t tx_req,
    output logic                   ack,
    output logic                   tx
);

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);

    logic [9:0]       frame;    // stop, data, start; shifted out lsb first
    logic [3:0]       bit_idx;  // bits already put on the line
    logic [CNT_W-1:0] clk_cnt;  // clocks left in the current bit
    logic             active;
    logic             tx_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack     <= 1'b0;
            active  <= 1'b0;
            tx_q    <= 1'b1;                // line idles high
            bit_idx <= '0;
            clk_cnt <= '0;
        end else if (active) begin
            if (clk_cnt != '0) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else if (bit_idx == 4'd10) begin
                active <= 1'b0;             // stop bit over
            end else begin
                tx_q    <= frame[0];
                clk_cnt <= BIT_LAST;
                bit_idx <= bit_idx + 1'b1;
            end
        end else if (ack) begin
            if (!tx_req.req) begin
                ack <= 1'b0;                // fourth phase
            end
        end else if (tx_req.req) begin
            ack     <= 1'b1;
            active  <= 1'b1;
            bit_idx <= '0;
            clk_cnt <= '0;                  // start bit goes out next cycle
        end
    end

    // frame payload, loaded on accept and shifted per bit
    always_ff @(posedge clk) begin
        if (!active && !ack && tx_req.req) begin
            frame <= {1'b1, tx_req.data, 1'b0};
        end else if (active && clk_cnt == '0 && bit_idx != 4'd10) begin
            frame <= {1'b1, frame[9:1]};
        end
    end

    assign tx = tx_q;

    // ack only answers a pending request
    a_ack_on_req : assert property (
        @(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(tx_req.req)
    );

endmodule

`default_nettype wire

/* design/capture_dump_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "capture_cfg.svh"

module capture_dump_top (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic sig,
    output logic tx,
    output logic busy,
    output logic done
);

    logic                   sample_en;
    logic [`CAP_WORD_W-1:0] word;
    logic                   word_stb;
    capture_pkg::ram_wr_t   wr;
    logic [`CAP_ADDR_W-1:0] rd_addr;
    logic [`CAP_WORD_W-1:0] rd_data;
    capture_pkg::byte_req_t tx_req;
    logic                   ack;

    bit_sampler sampler0 (
        .clk      (clk),
        .rst      (rst),
        .enable   (sample_en),
        .sig      (sig),
        .word     (word),
        .word_stb (word_stb)
    );

    capture_ram ram0 (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    dump_sequencer seq0 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .word      (word),
        .word_stb  (word_stb),
        .sample_en (sample_en),
        .wr        (wr),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .tx_req    (tx_req),
        .ack       (ack),
        .busy      (busy),
        .done      (done)
    );

    uart_tx uart0 (
        .clk    (clk),
        .rst    (rst),
        .tx_req (tx_req),
        .ack    (ack),
        .tx     (tx)
    );

endmodule

`default_nettype wire

/* test/tb_capture_dump.sv */
`timescale 1ns/100ps
`default_nettype none

`include "capture_cfg.svh"

module tb_capture_dump;

    localparam int CPB       = `UART_CLKS_PER_BIT;
    localparam int N_WORDS   = 2 ** `CAP_ADDR_W;
    localparam int N_SAMPLES = N_WORDS * `CAP_WORD_W;
    localparam int N_BYTES   = 2 * N_WORDS;
    // two runs of capture plus dump, and a quarter on top for handshakes
    localparam int TIMEOUT_CYCLES = 2 * (N_SAMPLES + N_BYTES * 10 * CPB) * 5 / 4;

    logic clk   = 1'b0;
    logic rst   = 1'b1;
    logic start = 1'b0;
    logic sig   = 1'b0;
    logic tx;
    logic busy;
    logic done;

    integer     seed = 32'hb1e2;
    logic       samples [$];                // reference bits by sample number
    logic [7:0] rx_buf [$];
    logic       recording = 1'b0;
    logic       busy_q = 1'b0;
    int         errors = 0;
    int         frame_errs = 0;             // per dump
    int         total_bytes = 0;
    int         cyc = 0;

    capture_dump_top dut0 (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .sig   (sig),
        .tx    (tx),
        .busy  (busy),
        .done  (done)
    );

    always #5 clk = ~clk;

    // fresh random level every cycle; logs the level the DUT takes on this edge
    always @(posedge clk) begin
        logic [31:0] rnd;
        if (busy === 1'b1 && busy_q !== 1'b1) begin
            samples.delete();               // capture begins on this edge
            recording = 1'b1;
        end
        if (recording) begin
            samples.push_back(sig);
            if (samples.size() == N_SAMPLES) begin
                recording = 1'b0;
            end
        end
        busy_q = busy;
        rnd = $random(seed);
        sig <= rnd[0];
    end

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the dump never completed", cyc);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // one 8N1 frame off tx, sampled mid-bit on falling edges
    task automatic rx_byte(output logic [7:0] data);
        data = 8'h00;
        @(negedge clk);
        while (tx !== 1'b0) begin
            @(negedge clk);
        end
        repeat (CPB / 2) @(negedge clk);
        if (tx !== 1'b0) begin
            errors++;
            frame_errs++;
            $display("start bit of byte %0d went high before mid-bit", rx_buf.size());
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CPB) @(negedge clk);
            data = {tx, data[7:1]};         // lsb arrives first
        end
        repeat (CPB) @(negedge clk);
        if (tx !== 1'b1) begin
            errors++;
            frame_errs++;
            $display("bad stop bit on byte %0d, the line was low", rx_buf.size());
        end
        total_bytes++;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // collects a whole dump, optionally with a start pulse after one byte
    task automatic receive_dump(input int pulse_after);
        logic [7:0] b;
        rx_buf.delete();
        frame_errs = 0;
        for (int k = 0; k < N_BYTES; k++) begin
            rx_byte(b);
            rx_buf.push_back(b);
            if (k == pulse_after) begin
                pulse_start();              // still inside the stop bit
                @(negedge clk);
                check_val("busy", 32'(busy), 32'd1);
                check_val("done", 32'(done), 32'd0);
            end
        end
    endtask

    task automatic wait_done();
        int waited;
        int low_cycles;
        waited = 0;
        low_cycles = 0;
        check_val("done", 32'(done), 32'd0);   // stop bit not over yet
        while (done !== 1'b1 && waited < 2 * CPB) begin
            @(negedge clk);
            waited++;
        end
        if (done !== 1'b1) begin
            errors++;
            $display("done did not rise after the final byte");
        end
        check_val("busy", 32'(busy), 32'd0);
        // a whole frame time of idle line, so no byte follows the last one
        repeat (10 * CPB) begin
            @(negedge clk);
            if (tx !== 1'b1) begin
                low_cycles++;
            end
        end
        if (low_cycles != 0) begin
            errors++;
            $display("tx went low after done, more bytes were sent than the RAM holds");
        end
    endtask

    task automatic test_reset_idle();
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i == 4) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            check_val("tx", 32'(tx), 32'd1);
            check_val("done", 32'(done), 32'd0);
            check_val("busy", 32'(busy), 32'd0);
        end
        @(negedge clk);                     // first cycle out of reset
        check_val("tx", 32'(tx), 32'd1);
        check_val("done", 32'(done), 32'd0);
    endtask

    task automatic test_frame_format();
        check_val("frame_errs", 32'(frame_errs), 32'd0);
    endtask

    task automatic test_capture_content();
        logic [`CAP_WORD_W-1:0] got;
        logic [`CAP_WORD_W-1:0] exp;
        for (int k = 0; k < N_WORDS; k++) begin
            got = {rx_buf[2*k+1], rx_buf[2*k]};
            exp = '0;
            for (int i = 0; i < `CAP_WORD_W; i++) begin
                exp = {exp[`CAP_WORD_W-2:0], samples[k*`CAP_WORD_W + i]};
            end
            check_val($sformatf("word[%0d]", k), 32'(got), 32'(exp));
        end
    endtask

    task automatic test_start_ignored_busy();
        receive_dump(100);
    endtask

    task automatic test_restart();
        int waited;
        pulse_start();
        waited = 0;
        @(negedge clk);
        while (done !== 1'b0 && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (done !== 1'b0) begin
            errors++;
            $display("done did not clear within 4 cycles of the start pulse");
        end
        receive_dump(-1);
        test_frame_format();
        test_capture_content();
        wait_done();
    endtask

    initial begin
        test_reset_idle();
        test_start_ignored_busy();
        test_frame_format();
        test_capture_content();
        wait_done();
        test_restart();
        $display("errors: %0d, bytes received: %0d, cycles: %0d", errors, total_bytes, cyc);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* capture_dump_top.f */
+incdir+design
design/capture_pkg.sv
design/bit_sampler.sv
design/capture_ram.sv
design/dump_sequencer.sv
design/uart_tx.sv
design/capture_dump_top.sv
test/tb_capture_dump.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the capture/dump testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=tb_capture_dump
LOG=sim.log

verilator --binary --timing --assert \
    -f capture_dump_top.f \
    --top-module "$TOP" \
    -o "V$TOP"

./obj_dir/"V$TOP" | tee "$LOG"

if grep -q "^NO ERRORS$" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi
